// ==== rtl/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

  // cpu bus geometry
  localparam int BUS_DATA_W = 16;
  localparam int BUS_ADDR_W = 14;
  localparam int BRAM_SEL_W = 2;

  typedef logic [BUS_DATA_W-1:0] bus_data_t;
  typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
  typedef logic [BRAM_SEL_W-1:0] bram_sel_t;

  // memory select, top bits of the word address
  localparam bram_sel_t BRAM_SELECT_CONTROLLER = 2'd0;
  localparam bram_sel_t BRAM_SELECT_NORMAL = 2'd1;

  // controller register map
  localparam bus_addr_t ADDR_CTL_FLAG = 14'd0;
  localparam bus_addr_t ADDR_SEGMENT = 14'd1;

  // bit positions inside the controller words
  localparam int CTL_FLAG_OUT_EN_BIT = 0;
  localparam int SEGMENT_BIT = 0;

  // one bus write as seen by the targets
  typedef struct packed {
    bram_sel_t sel;
    bus_addr_t addr;
    bus_data_t data;
  } bus_wr_t;

endpackage

// ==== rtl/drive_pkg.sv ====
package drive_pkg;

  localparam int NUM_TRANS = 8;
  localparam int TRANS_IDX_W = $clog2(NUM_TRANS);
  // two segments of NUM_TRANS words each
  localparam int MEM_DEPTH = 2 * NUM_TRANS;
  // normal memory address bit that picks the segment
  localparam int SEG_ADDR_BIT = 8;

  // widths in carrier counts
  typedef logic [7:0] intensity_t;
  typedef logic [7:0] phase_t;
  typedef logic [7:0] cycle_cnt_t;
  typedef logic [TRANS_IDX_W-1:0] trans_idx_t;
  // segment bit on top of the transducer index
  typedef logic [TRANS_IDX_W:0] mem_addr_t;

  typedef struct packed {
    trans_idx_t idx;
    intensity_t intensity;
    phase_t phase;
  } drive_entry_t;

endpackage

// ==== rtl/cpu_bus_bridge.sv ====
`timescale 1ns/10ps
module cpu_bus_bridge
  import cpu_bus_pkg::*;
(
  input  logic                           CPU_CKIO,
  input  logic                           rst_n,
  input  logic [BRAM_SEL_W+BUS_ADDR_W-1:0] cpu_addr,
  input  bus_data_t                      cpu_data,
  input  logic                           cs_n,
  input  logic                           we_n,
  input  logic                           wr_ready,
  input  bus_data_t                      rd_data,
  output bus_wr_t                        wr,
  output logic                           wr_valid,
  output bus_addr_t                      rd_addr,
  output bus_data_t                      CPU_DATA_READ
);

  bram_sel_t sel_q;
  bus_addr_t addr_q;
  bus_data_t data_q;
  logic      cs_n_q;
  logic      we_n_q;
  logic      we_n_qq;
  logic      wr_strobe;
  logic      wr_accept;
  logic      rd_en;
  logic      rd_en_d;

  // pin sample, address and data
  always_ff @(posedge CPU_CKIO) begin
    sel_q  <= cpu_addr[BRAM_SEL_W+BUS_ADDR_W-1 -: BRAM_SEL_W];
    addr_q <= cpu_addr[BUS_ADDR_W-1:0];
    data_q <= cpu_data;
  end

  // strobes idle high
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      cs_n_q  <= 1'b1;
      we_n_q  <= 1'b1;
      we_n_qq <= 1'b1;
    end else begin
      cs_n_q  <= cs_n;
      we_n_q  <= we_n;
      we_n_qq <= we_n_q;
    end
  end

  // we falling under cs
  assign wr_strobe = ~cs_n_q & we_n_qq & ~we_n_q;
  // normal memory never stalls, only the controller can refuse
  assign wr_accept = wr_valid & ((wr.sel != BRAM_SELECT_CONTROLLER) | wr_ready);

  always_ff @(posedge CPU_CKIO) begin
    if (wr_strobe) begin
      wr <= '{sel: sel_q, addr: addr_q, data: data_q};
    end
  end

  // request held until accepted
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      wr_valid <= 1'b0;
    end else if (wr_strobe) begin
      wr_valid <= 1'b1;
    end else if (wr_accept) begin
      wr_valid <= 1'b0;
    end
  end

  // controller reads only
  assign rd_en   = ~cs_n_q & we_n_q & (sel_q == BRAM_SELECT_CONTROLLER);
  assign rd_addr = addr_q;

  // regs answer next cycle, returned one cycle after that
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      rd_en_d       <= 1'b0;
      CPU_DATA_READ <= '0;
    end else begin
      rd_en_d       <= rd_en;
      CPU_DATA_READ <= rd_en_d ? rd_data : '0;
    end
  end

endmodule

// ==== rtl/ctl_regs.sv ====
`timescale 1ns/10ps
module ctl_regs
  import cpu_bus_pkg::*;
(
  input  logic      CPU_CKIO,
  input  logic      rst_n,
  input  bus_wr_t   wr,
  input  logic      wr_valid,
  input  bus_addr_t rd_addr,
  output logic      wr_ready,
  output bus_data_t rd_data,
  output logic      out_enable,
  output logic      active_segment
);

  logic wr_fire;
  logic seg_pend;
  logic seg_next;

  // controller select only
  assign wr_fire = wr_valid & wr_ready & (wr.sel == BRAM_SELECT_CONTROLLER);

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      wr_ready       <= 1'b0;
      out_enable     <= 1'b0;
      active_segment <= 1'b0;
      seg_pend       <= 1'b0;
      seg_next       <= 1'b0;
    end else begin
      // one cycle of back pressure per write
      wr_ready <= ~wr_fire;
      seg_pend <= wr_fire & (wr.addr == ADDR_SEGMENT);
      if (wr_fire && wr.addr == ADDR_CTL_FLAG) begin
        out_enable <= wr.data[CTL_FLAG_OUT_EN_BIT];
      end
      if (wr_fire && wr.addr == ADDR_SEGMENT) begin
        seg_next <= wr.data[SEGMENT_BIT];
      end
      // segment committed in the stalled cycle
      if (seg_pend) begin
        active_segment <= seg_next;
      end
    end
  end

  // readback mux, unmapped reads return zero
  always_ff @(posedge CPU_CKIO) begin
    rd_data <= '0;
    case (rd_addr)
      ADDR_CTL_FLAG: rd_data[CTL_FLAG_OUT_EN_BIT] <= out_enable;
      ADDR_SEGMENT:  rd_data[SEGMENT_BIT] <= active_segment;
      default:       rd_data <= '0;
    endcase
  end

endmodule

// ==== rtl/drive_mem.sv ====
`timescale 1ns/10ps
module drive_mem
  import cpu_bus_pkg::*, drive_pkg::*;
(
  input  logic      CPU_CKIO,
  input  bus_wr_t   wr,
  input  logic      wr_en,
  input  mem_addr_t rd_addr,
  output bus_data_t rd_word
);

  // word is intensity high byte, phase low byte
  bus_data_t mem [MEM_DEPTH];
  mem_addr_t wr_addr;
  logic      wr_hit;

  // segment bit over transducer index
  assign wr_addr = {wr.addr[SEG_ADDR_BIT], wr.addr[TRANS_IDX_W-1:0]};

  // index bits above the array size must be clear
  assign wr_hit = wr_en && (wr.addr[SEG_ADDR_BIT-1:TRANS_IDX_W] == '0);

  always_ff @(posedge CPU_CKIO) begin
    if (wr_hit) begin
      mem[wr_addr] <= wr.data;
    end
  end

  // synchronous read for the loader
  always_ff @(posedge CPU_CKIO) begin
    rd_word <= mem[rd_addr];
  end

endmodule

// ==== rtl/drive_loader.sv ====
`timescale 1ns/10ps
module drive_loader
  import cpu_bus_pkg::*, drive_pkg::*;
(
  input  logic         CPU_CKIO,
  input  logic         rst_n,
  input  logic         active_segment,
  input  bus_data_t    rd_word,
  output mem_addr_t    rd_addr,
  output drive_entry_t entry,
  output logic         entry_valid,
  output logic         cycle_start,
  output cycle_cnt_t   cycle_cnt
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SCAN,
    ST_DRAIN
  } state_t;

  state_t     state;
  trans_idx_t rd_idx;
  trans_idx_t ret_idx;
  logic       seg_q;
  logic       wrapped;
  logic       rd_issue;

  // no period start before the first wrap
  assign cycle_start = wrapped & (cycle_cnt == '0);
  // first read goes out with cycle_start
  assign rd_issue    = ((state == ST_IDLE) & cycle_start) | (state == ST_SCAN);
  assign rd_addr     = {seg_q, rd_idx};

  // carrier counter, segment frozen for the coming period
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
      wrapped   <= 1'b0;
      seg_q     <= 1'b0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
      if (cycle_cnt == '1) begin
        wrapped <= 1'b1;
        seg_q   <= active_segment;
      end
    end
  end

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      state  <= ST_IDLE;
      rd_idx <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cycle_start) begin
            state  <= ST_SCAN;
            rd_idx <= rd_idx + 1'b1;
          end
        end
        ST_SCAN: begin
          if (rd_idx == trans_idx_t'(NUM_TRANS - 1)) begin
            state  <= ST_DRAIN;
            rd_idx <= '0;
          end else begin
            rd_idx <= rd_idx + 1'b1;
          end
        end
        // last word still in flight
        ST_DRAIN: state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // index follows the memory latency
  always_ff @(posedge CPU_CKIO) begin
    ret_idx <= rd_idx;
  end

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      entry_valid <= 1'b0;
    end else begin
      entry_valid <= rd_issue;
    end
  end

  assign entry = '{idx: ret_idx, intensity: rd_word[15:8], phase: rd_word[7:0]};

endmodule

// ==== rtl/pwm_channel.sv ====
`timescale 1ns/10ps
module pwm_channel
  import drive_pkg::*;
#(
  parameter int CH_IDX = 0
) (
  input  logic         CPU_CKIO,
  input  logic         rst_n,
  input  drive_entry_t entry,
  input  logic         entry_valid,
  input  logic         cycle_start,
  input  cycle_cnt_t   cycle_cnt,
  output logic         pwm
);

  intensity_t shadow_int;
  intensity_t act_int;
  intensity_t cur_int;
  phase_t     shadow_ph;
  phase_t     act_ph;
  phase_t     cur_ph;
  cycle_cnt_t rel_cnt;

  // shadow already counts at period start
  assign cur_int = cycle_start ? shadow_int : act_int;
  assign cur_ph  = cycle_start ? shadow_ph : act_ph;
  // wraps modulo 256
  assign rel_cnt = cycle_cnt - cur_ph;

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      shadow_int <= '0;
      shadow_ph  <= '0;
      act_int    <= '0;
      act_ph     <= '0;
      pwm        <= 1'b0;
    end else begin
      if (entry_valid && entry.idx == trans_idx_t'(CH_IDX)) begin
        shadow_int <= entry.intensity;
        shadow_ph  <= entry.phase;
      end
      act_int <= cur_int;
      act_ph  <= cur_ph;
      pwm     <= rel_cnt < cur_int;
    end
  end

endmodule

// ==== rtl/pwm_output_stage.sv ====
`timescale 1ns/10ps
module pwm_output_stage
  import drive_pkg::*;
(
  input  logic                 CPU_CKIO,
  input  logic                 rst_n,
  input  logic [NUM_TRANS-1:0] pwm_raw,
  input  logic                 out_enable,
  input  logic                 cycle_start,
  output logic [NUM_TRANS-1:0] pwm_out,
  output logic                 cycle_sync
);

  logic start_d;

  // sync delayed twice, same as channel plus output register
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      pwm_out    <= '0;
      start_d    <= 1'b0;
      cycle_sync <= 1'b0;
    end else begin
      pwm_out    <= out_enable ? pwm_raw : '0;
      start_d    <= cycle_start;
      cycle_sync <= start_d;
    end
  end

endmodule

// ==== rtl/transducer_array_top.sv ====
`timescale 1ns/10ps
module transducer_array_top
  import cpu_bus_pkg::*, drive_pkg::*;
(
  input  logic                           CPU_CKIO,
  input  logic                           rst_n,
  // bit 0 is the byte lane, unused
  input  logic [BRAM_SEL_W+BUS_ADDR_W:0] CPU_ADDR,
  input  bus_data_t                      CPU_DATA,
  input  logic                           CPU_CS1_N,
  input  logic                           CPU_WE0_N,
  output bus_data_t                      CPU_DATA_READ,
  output logic [NUM_TRANS-1:0]           pwm_out,
  output logic                           cycle_sync
);

  bus_wr_t              wr;
  logic                 wr_valid;
  logic                 wr_ready;
  bus_addr_t            ctl_rd_addr;
  bus_data_t            ctl_rd_data;
  logic                 out_enable;
  logic                 active_segment;
  logic                 mem_wr_en;
  mem_addr_t            mem_rd_addr;
  bus_data_t            mem_rd_word;
  drive_entry_t         entry;
  logic                 entry_valid;
  logic                 cycle_start;
  cycle_cnt_t           cycle_cnt;
  logic [NUM_TRANS-1:0] pwm_raw;

  cpu_bus_bridge u_bridge (
    .CPU_CKIO     (CPU_CKIO),
    .rst_n        (rst_n),
    .cpu_addr     (CPU_ADDR[BRAM_SEL_W+BUS_ADDR_W:1]),
    .cpu_data     (CPU_DATA),
    .cs_n         (CPU_CS1_N),
    .we_n         (CPU_WE0_N),
    .wr_ready     (wr_ready),
    .rd_data      (ctl_rd_data),
    .wr           (wr),
    .wr_valid     (wr_valid),
    .rd_addr      (ctl_rd_addr),
    .CPU_DATA_READ(CPU_DATA_READ)
  );

  ctl_regs u_ctl (
    .CPU_CKIO      (CPU_CKIO),
    .rst_n         (rst_n),
    .wr            (wr),
    .wr_valid      (wr_valid),
    .rd_addr       (ctl_rd_addr),
    .wr_ready      (wr_ready),
    .rd_data       (ctl_rd_data),
    .out_enable    (out_enable),
    .active_segment(active_segment)
  );

  // normal memory takes every write on its select
  assign mem_wr_en = wr_valid & (wr.sel == BRAM_SELECT_NORMAL);

  drive_mem u_mem (
    .CPU_CKIO(CPU_CKIO),
    .wr      (wr),
    .wr_en   (mem_wr_en),
    .rd_addr (mem_rd_addr),
    .rd_word (mem_rd_word)
  );

  drive_loader u_loader (
    .CPU_CKIO      (CPU_CKIO),
    .rst_n         (rst_n),
    .active_segment(active_segment),
    .rd_word       (mem_rd_word),
    .rd_addr       (mem_rd_addr),
    .entry         (entry),
    .entry_valid   (entry_valid),
    .cycle_start   (cycle_start),
    .cycle_cnt     (cycle_cnt)
  );

  // one channel per transducer
  for (genvar i = 0; i < NUM_TRANS; i++) begin : g_ch
    pwm_channel #(
      .CH_IDX(i)
    ) u_ch (
      .CPU_CKIO   (CPU_CKIO),
      .rst_n      (rst_n),
      .entry      (entry),
      .entry_valid(entry_valid),
      .cycle_start(cycle_start),
      .cycle_cnt  (cycle_cnt),
      .pwm        (pwm_raw[i])
    );
  end

  pwm_output_stage u_out (
    .CPU_CKIO   (CPU_CKIO),
    .rst_n      (rst_n),
    .pwm_raw    (pwm_raw),
    .out_enable (out_enable),
    .cycle_start(cycle_start),
    .pwm_out    (pwm_out),
    .cycle_sync (cycle_sync)
  );

endmodule

// ==== verification/tb_transducer_array.sv ====
`timescale 1ns/10ps
module tb_transducer_array
  import cpu_bus_pkg::*, drive_pkg::*;
();

  logic                 CPU_CKIO;
  logic                 rst_n;
  logic [16:0]          CPU_ADDR;
  bus_data_t            CPU_DATA;
  logic                 CPU_CS1_N;
  logic                 CPU_WE0_N;
  bus_data_t            CPU_DATA_READ;
  logic [NUM_TRANS-1:0] pwm_out;
  logic                 cycle_sync;

  // reference copy of both segments
  intensity_t ref_int [2][NUM_TRANS];
  phase_t     ref_ph [2][NUM_TRANS];
  int         hi_cnt [NUM_TRANS];
  int         first_hi [NUM_TRANS];
  logic [31:0] lfsr;
  int         errors;
  int         n_pass;
  int         n_fail;
  int         mark;
  bus_data_t  rd;
  event       abort_ev;

  transducer_array_top DUT (.*);

  initial begin
    CPU_CKIO = 1'b0;
    forever #4 CPU_CKIO = ~CPU_CKIO;
  end

  // sync is a single-cycle pulse
  sync_pulse: assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
    cycle_sync |=> !cycle_sync)
    else begin
      $display("cycle_sync stayed high for more than one cycle");
      errors++;
    end

  initial begin
    @(abort_ev);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [7:0] get_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      // galois step per bit taken
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v[b] = lfsr[0];
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got == exp)
      else begin
        $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        errors++;
      end
  endtask

  task automatic bus_write(input bram_sel_t sel, input bus_addr_t addr, input bus_data_t data);
    int t;
    @(posedge CPU_CKIO);
    CPU_ADDR  <= {sel, addr, 1'b0};
    CPU_DATA  <= data;
    CPU_CS1_N <= 1'b0;
    CPU_WE0_N <= 1'b1;
    @(posedge CPU_CKIO);
    CPU_WE0_N <= 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    CPU_WE0_N <= 1'b1;
    @(posedge CPU_CKIO);
    CPU_CS1_N <= 1'b1;
    // request must be gone before the next access
    t = 0;
    while (DUT.wr_valid && t < 20) begin
      @(posedge CPU_CKIO);
      t++;
    end
    if (DUT.wr_valid) begin
      $display("write request was never accepted");
      -> abort_ev;
      #1;
    end
  endtask

  task automatic bus_read(input bram_sel_t sel, input bus_addr_t addr, output bus_data_t data);
    @(posedge CPU_CKIO);
    CPU_ADDR  <= {sel, addr, 1'b0};
    CPU_CS1_N <= 1'b0;
    CPU_WE0_N <= 1'b1;
    // this edge samples the read
    @(posedge CPU_CKIO);
    CPU_CS1_N <= 1'b1;
    repeat (2) @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
    data = CPU_DATA_READ;
  endtask

  task automatic wait_sync();
    int t;
    t = 0;
    @(negedge CPU_CKIO);
    while (!cycle_sync && t < 600) begin
      @(negedge CPU_CKIO);
      t++;
    end
    if (!cycle_sync) begin
      $display("timed out waiting for cycle_sync");
      -> abort_ev;
      #1;
    end
  endtask

  // one carrier period starting at cycle_sync
  task automatic measure_period();
    for (int i = 0; i < NUM_TRANS; i++) begin
      hi_cnt[i]   = 0;
      first_hi[i] = -1;
    end
    wait_sync();
    for (int j = 0; j < 256; j++) begin
      for (int i = 0; i < NUM_TRANS; i++) begin
        if (pwm_out[i]) begin
          hi_cnt[i]++;
          if (first_hi[i] < 0) begin
            first_hi[i] = j;
          end
        end
      end
      @(negedge CPU_CKIO);
    end
  endtask

  task automatic load_segment(input logic seg);
    logic [7:0] in_v;
    logic [7:0] ph_v;
    for (int i = 0; i < NUM_TRANS; i++) begin
      in_v = get_bits(8);
      ph_v = get_bits(8);
      // one silent channel per segment
      if (i == int'(seg)) in_v = 8'd0;
      ref_int[seg][i] = in_v;
      ref_ph[seg][i]  = ph_v;
      bus_write(BRAM_SELECT_NORMAL, bus_addr_t'({5'd0, seg, 8'(i)}), {in_v, ph_v});
    end
  endtask

  task automatic check_duty(input logic seg);
    for (int i = 0; i < NUM_TRANS; i++) begin
      check_val($sformatf("pwm_out[%0d] high count", i), 16'(hi_cnt[i]),
                16'(ref_int[seg][i]));
    end
  endtask

  task automatic check_phase(input logic seg);
    for (int i = 0; i < NUM_TRANS; i++) begin
      if (ref_int[seg][i] != 0 && int'(ref_int[seg][i]) + int'(ref_ph[seg][i]) <= 256) begin
        check_val($sformatf("pwm_out[%0d] rise offset", i), 16'(first_hi[i]),
                  16'(ref_ph[seg][i]));
      end
    end
  endtask

  task automatic settle_measure();
    repeat (3) wait_sync();
    measure_period();
  endtask

  task automatic end_test(input string name);
    if (errors == mark) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", name, errors - mark);
    end
    mark = errors;
  endtask

  initial begin
    lfsr      = 32'd95566;
    errors    = 0;
    n_pass    = 0;
    n_fail    = 0;
    mark      = 0;
    rst_n     = 1'b0;
    CPU_ADDR  = '0;
    CPU_DATA  = '0;
    CPU_CS1_N = 1'b1;
    CPU_WE0_N = 1'b1;
    repeat (3) @(posedge CPU_CKIO);
    rst_n <= 1'b1;

    @(negedge CPU_CKIO);
    check_val("pwm_out", 16'(pwm_out), 16'h0);
    bus_read(BRAM_SELECT_CONTROLLER, ADDR_CTL_FLAG, rd);
    check_val("CPU_DATA_READ flag", rd, 16'h0);
    bus_read(BRAM_SELECT_CONTROLLER, ADDR_SEGMENT, rd);
    check_val("CPU_DATA_READ segment", rd, 16'h0);
    end_test("reset");

    bus_write(BRAM_SELECT_CONTROLLER, ADDR_SEGMENT, 16'h1);
    bus_read(BRAM_SELECT_CONTROLLER, ADDR_SEGMENT, rd);
    check_val("CPU_DATA_READ segment", rd, 16'h1);
    bus_write(BRAM_SELECT_CONTROLLER, ADDR_SEGMENT, 16'h0);
    bus_read(BRAM_SELECT_CONTROLLER, ADDR_SEGMENT, rd);
    check_val("CPU_DATA_READ segment", rd, 16'h0);
    bus_write(BRAM_SELECT_CONTROLLER, ADDR_CTL_FLAG, 16'h1);
    bus_read(BRAM_SELECT_CONTROLLER, ADDR_CTL_FLAG, rd);
    check_val("CPU_DATA_READ flag", rd, 16'h1);
    end_test("readback");

    load_segment(1'b0);
    settle_measure();
    check_duty(1'b0);
    end_test("duty");
    check_phase(1'b0);
    end_test("phase");

    load_segment(1'b1);
    bus_write(BRAM_SELECT_CONTROLLER, ADDR_SEGMENT, 16'h1);
    settle_measure();
    check_duty(1'b1);
    check_phase(1'b1);
    bus_write(BRAM_SELECT_CONTROLLER, ADDR_SEGMENT, 16'h0);
    settle_measure();
    check_duty(1'b0);
    check_phase(1'b0);
    end_test("segment switch");

    bus_write(BRAM_SELECT_CONTROLLER, ADDR_CTL_FLAG, 16'h0);
    settle_measure();
    for (int i = 0; i < NUM_TRANS; i++) begin
      check_val($sformatf("pwm_out[%0d] high count", i), 16'(hi_cnt[i]), 16'h0);
    end
    wait_sync();
    end_test("enable");

    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
rtl/cpu_bus_pkg.sv
rtl/drive_pkg.sv
rtl/cpu_bus_bridge.sv
rtl/ctl_regs.sv
rtl/drive_mem.sv
rtl/drive_loader.sv
rtl/pwm_channel.sv
rtl/pwm_output_stage.sv
rtl/transducer_array_top.sv
verification/tb_transducer_array.sv

// ==== Makefile ====
SRCS := $(wildcard rtl/*.sv) verification/tb_transducer_array.sv
BIN := obj_dir/Vtb_transducer_array

.PHONY: all run clean

all: run

$(BIN): $(SRCS) files.f
	verilator --binary --timing --assert -f files.f --top-module tb_transducer_array -Mdir obj_dir

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
